// ==== hw/pid_cfg_pkg.sv ====
package pid_cfg_pkg;

    // Actuator side widths
    localparam int DATA_W = 8;
    localparam int CODE_W = 4;

    // Decoded gains are unsigned, scaled by GAIN_SCALE
    localparam int GAIN_W = 9;
    localparam int GAIN_SCALE = 50;

    // Signed error, and the signed difference of two errors
    localparam int ERR_W = 9;
    localparam int DIFF_W = ERR_W + 1;

    // Upper limit of the output clamp
    localparam int OUT_MAX = 255;

    // Gain per 4-bit code, real factor times GAIN_SCALE
    localparam logic [GAIN_W-1:0] GAIN_TABLE [16] = '{
        9'd0,   9'd5,   9'd10,  9'd15,
        9'd20,  9'd25,  9'd30,  9'd35,
        9'd40,  9'd45,  9'd50,  9'd100,
        9'd150, 9'd250, 9'd350, 9'd500
    };

endpackage

// ==== hw/pid_types_pkg.sv ====
package pid_types_pkg;

    // Target of a gain load
    typedef enum logic [1:0] {
        KP,
        KI,
        KD
    } gain_sel_e;

    typedef struct packed {
        logic                            strobe;
        gain_sel_e                       sel;
        logic [pid_cfg_pkg::CODE_W-1:0]  code;
    } gain_load_t;

    // Active gains, unsigned and scaled
    typedef struct packed {
        logic [pid_cfg_pkg::GAIN_W-1:0] kp;
        logic [pid_cfg_pkg::GAIN_W-1:0] ki;
        logic [pid_cfg_pkg::GAIN_W-1:0] kd;
    } gain_set_t;

    typedef struct packed {
        logic [pid_cfg_pkg::DATA_W-1:0] setpoint;
        logic [pid_cfg_pkg::DATA_W-1:0] feedback;
    } sample_t;

    // Error of the current sample and its change since the last one
    typedef struct packed {
        logic signed [pid_cfg_pkg::ERR_W-1:0]  error;
        logic signed [pid_cfg_pkg::DIFF_W-1:0] diff;
    } err_pair_t;

endpackage

// ==== hw/pid_sequencer.sv ====
`timescale 1ns/1ps

module pid_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_strobe,
    input  logic [pid_cfg_pkg::CODE_W-1:0] gain_code,
    input  logic                           sample_strobe,
    input  logic                           reload_strobe,
    output pid_types_pkg::gain_load_t      gain_load,
    output logic                           sample_go,
    output logic                           clear,
    output logic                           running
);
    import pid_types_pkg::*;

    typedef enum logic [1:0] {
        LOAD_KP,
        LOAD_KI,
        LOAD_KD,
        RUN
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_next;

    always_comb begin
        state_next = state;
        if (reload_strobe) begin
            state_next = LOAD_KP;
        end else begin
            unique case (state)
                LOAD_KP: if (cfg_strobe) state_next = LOAD_KI;
                LOAD_KI: if (cfg_strobe) state_next = LOAD_KD;
                LOAD_KD: if (cfg_strobe) state_next = RUN;
                RUN:     state_next = RUN;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LOAD_KP;
        end else begin
            state <= state_next;
        end
    end

    // Load command follows the strobe in the same cycle
    always_comb begin
        gain_load.strobe = cfg_strobe && (state != RUN) && !reload_strobe;
        gain_load.code   = gain_code;
        unique case (state)
            LOAD_KI: gain_load.sel = KI;
            LOAD_KD: gain_load.sel = KD;
            default: gain_load.sel = KP;
        endcase
    end

    // Samples pass only while running
    assign sample_go = sample_strobe && (state == RUN) && !reload_strobe;
    assign clear     = reload_strobe;
    assign running   = (state == RUN);

endmodule

// ==== hw/gain_table.sv ====
`timescale 1ns/1ps

module gain_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pid_types_pkg::gain_load_t gain_load,
    output pid_types_pkg::gain_set_t  gains
);
    import pid_cfg_pkg::*;
    import pid_types_pkg::*;

    logic [GAIN_W-1:0] decoded;

    // Code to scaled gain
    assign decoded = GAIN_TABLE[gain_load.code];

    // Only the selected gain is written, the other two are kept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gains.kp <= '0;
            gains.ki <= '0;
            gains.kd <= '0;
        end else if (gain_load.strobe) begin
            unique case (gain_load.sel)
                KP: gains.kp <= decoded;
                KI: gains.ki <= decoded;
                KD: gains.kd <= decoded;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/error_stage.sv ====
`timescale 1ns/1ps

module error_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_go,
    input  logic                     clear,
    input  pid_types_pkg::sample_t   sample,
    output pid_types_pkg::err_pair_t err,
    output logic                     stage_valid
);
    import pid_cfg_pkg::*;

    logic signed [ERR_W-1:0]  error_now;
    logic signed [DIFF_W-1:0] diff_now;
    logic signed [ERR_W-1:0]  prev_error;

    // Both inputs are unsigned, so widen by one bit before subtracting
    assign error_now = $signed({1'b0, sample.setpoint}) - $signed({1'b0, sample.feedback});
    assign diff_now  = DIFF_W'(error_now) - DIFF_W'(prev_error);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            prev_error  <= '0;
        end else begin
            stage_valid <= sample_go;
            if (clear) begin
                prev_error <= '0;
            end else if (sample_go) begin
                prev_error <= error_now;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_go) begin
            err.error <= error_now;
            err.diff  <= diff_now;
        end
    end

endmodule

// ==== hw/term_engine.sv ====
`timescale 1ns/1ps

module term_engine #(
    parameter int ACC_W = 18
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           stage_valid,
    input  logic                           clear,
    input  pid_types_pkg::err_pair_t       err,
    input  pid_types_pkg::gain_set_t       gains,
    output logic [pid_cfg_pkg::DATA_W-1:0] control_out,
    output logic                           out_valid
);
    import pid_cfg_pkg::*;

    // Unsigned gain widened by a sign bit, times the wider difference
    localparam int PROD_W = GAIN_W + 1 + DIFF_W;
    localparam logic signed [PROD_W-1:0] SCALE = PROD_W'(GAIN_SCALE);
    localparam logic signed [ACC_W-1:0] ACC_MAX = ACC_W'(OUT_MAX);

    logic signed [PROD_W-1:0] p_prod;
    logic signed [PROD_W-1:0] i_prod;
    logic signed [PROD_W-1:0] d_prod;
    logic signed [PROD_W-1:0] p_quot;
    logic signed [PROD_W-1:0] i_quot;
    logic signed [PROD_W-1:0] d_quot;

    logic signed [ACC_W-1:0] integral;
    logic signed [ACC_W-1:0] integral_next;
    logic signed [ACC_W-1:0] sum;
    logic [DATA_W-1:0]       clamped;

    always_comb begin
        p_prod = PROD_W'($signed({1'b0, gains.kp})) * PROD_W'($signed(err.error));
        i_prod = PROD_W'($signed({1'b0, gains.ki})) * PROD_W'($signed(err.error));
        d_prod = PROD_W'($signed({1'b0, gains.kd})) * PROD_W'($signed(err.diff));

        // Signed division truncates toward zero
        p_quot = p_prod / SCALE;
        i_quot = i_prod / SCALE;
        d_quot = d_prod / SCALE;

        // Integral wraps at ACC_W
        integral_next = integral + ACC_W'(i_quot);
        sum           = ACC_W'(p_quot) + integral_next + ACC_W'(d_quot);
    end

    always_comb begin
        if (sum <= 0) begin
            clamped = '0;
        end else if (sum >= ACC_MAX) begin
            clamped = DATA_W'(OUT_MAX);
        end else begin
            clamped = sum[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            integral    <= '0;
            control_out <= '0;
            out_valid   <= 1'b0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                control_out <= clamped;
            end
            // Reload wins over a sample still in this stage
            if (clear) begin
                integral <= '0;
            end else if (stage_valid) begin
                integral <= integral_next;
            end
        end
    end

endmodule

// ==== hw/pid_loop_top.sv ====
`timescale 1ns/1ps

module pid_loop_top #(
    parameter int ACC_W = 18
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_strobe,
    input  logic [pid_cfg_pkg::CODE_W-1:0] gain_code,
    input  logic                           sample_strobe,
    input  pid_types_pkg::sample_t         sample,
    input  logic                           reload_strobe,
    output logic [pid_cfg_pkg::DATA_W-1:0] control_out,
    output logic                           out_valid,
    output logic                           running
);
    import pid_types_pkg::*;

    gain_load_t gain_load;
    gain_set_t  gains;
    err_pair_t  err;
    logic       sample_go;
    logic       clear;
    logic       stage_valid;

    pid_sequencer pid_sequencer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_strobe    (cfg_strobe),
        .gain_code     (gain_code),
        .sample_strobe (sample_strobe),
        .reload_strobe (reload_strobe),
        .gain_load     (gain_load),
        .sample_go     (sample_go),
        .clear         (clear),
        .running       (running)
    );

    gain_table gain_table_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .gain_load (gain_load),
        .gains     (gains)
    );

    error_stage error_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_go   (sample_go),
        .clear       (clear),
        .sample      (sample),
        .err         (err),
        .stage_valid (stage_valid)
    );

    term_engine #(
        .ACC_W (ACC_W)
    ) term_engine_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .clear       (clear),
        .err         (err),
        .gains       (gains),
        .control_out (control_out),
        .out_valid   (out_valid)
    );

endmodule

// ==== bench/pid_loop_properties.sv ====
`timescale 1ns/1ps

module pid_loop_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     sample_go,
    input logic                     out_valid,
    input logic                     running,
    input pid_types_pkg::gain_set_t gains
);

    // Failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Accepted sample reaches the output after two edges
    sample_to_output: assert property (
        @(posedge clk) disable iff (!rst_n) sample_go |-> ##2 out_valid
    ) else begin
        $error("out_valid missing two cycles after an accepted sample");
        fail_count++;
    end

    // No output without a sample two cycles earlier
    output_has_sample: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> $past(sample_go, 2)
    ) else begin
        $error("out_valid without an accepted sample two cycles earlier");
        fail_count++;
    end

    // Gains stay frozen in RUN
    gains_frozen_in_run: assert property (
        @(posedge clk) disable iff (!rst_n) running |=> $stable(gains)
    ) else begin
        $error("active gains changed while running");
        fail_count++;
    end

endmodule

bind pid_loop_top pid_loop_properties pid_loop_properties_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .sample_go (sample_go),
    .out_valid (out_valid),
    .running   (running),
    .gains     (gains)
);

// ==== bench/tb_pid_loop.sv ====
`timescale 1ns/1ps

module tb_pid_loop;
    import pid_cfg_pkg::*;
    import pid_types_pkg::*;

    localparam int ACC_W = 18;
    localparam int MAX_CYCLES = 3000;

    logic              clk;
    logic              rst_n;
    logic              cfg_strobe;
    logic [CODE_W-1:0] gain_code;
    logic              sample_strobe;
    sample_t           sample;
    logic              reload_strobe;
    logic [DATA_W-1:0] control_out;
    logic              out_valid;
    logic              running;

    // Gain per code, times 50
    int gain_lut [16] = '{0, 5, 10, 15, 20, 25, 30, 35, 40, 45, 50, 100, 150, 250, 350, 500};

    int kp;
    int ki;
    int kd;
    int integ;
    int prev_e;
    int errors;
    int cycles;
    int assert_fails;
    logic [DATA_W-1:0] exp_q [$];

    pid_loop_top #(
        .ACC_W (ACC_W)
    ) pid_loop_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_strobe    (cfg_strobe),
        .gain_code     (gain_code),
        .sample_strobe (sample_strobe),
        .sample        (sample),
        .reload_strobe (reload_strobe),
        .control_out   (control_out),
        .out_valid     (out_valid),
        .running       (running)
    );

    always #20 clk = ~clk;

    task automatic check_out(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Two's complement wrap to the accumulator width
    function automatic int wrap_acc(input int v);
        logic [ACC_W-1:0] low;
        low = v[ACC_W-1:0];
        return $signed(low);
    endfunction

    task automatic model(input int sp, input int fb);
        int e;
        int p;
        int d;
        int s;
        e = sp - fb;
        p = kp * e / GAIN_SCALE;
        integ = wrap_acc(integ + ki * e / GAIN_SCALE);
        d = kd * (e - prev_e) / GAIN_SCALE;
        prev_e = e;
        s = wrap_acc(p + integ + d);
        if (s <= 0) begin
            exp_q.push_back('0);
        end else if (s >= OUT_MAX) begin
            exp_q.push_back(DATA_W'(OUT_MAX));
        end else begin
            exp_q.push_back(DATA_W'(s));
        end
    endtask

    // Outputs are stable away from the rising edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid high with no sample pending, control_out %h", control_out);
                errors++;
            end else begin
                check_out("control_out", exp_q.pop_front(), control_out);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, run did not finish", cycles);
            $display("Checks done, %0d errors", errors);
            $display("TB FAILED");
            $finish;
        end
    end

    // Called 2 ns after an edge, returns at the same point
    task automatic send_sample(input int sp, input int fb, input bit accepted);
        sample_strobe   = 1'b1;
        sample.setpoint = DATA_W'(sp);
        sample.feedback = DATA_W'(fb);
        if (accepted) begin
            model(sp, fb);
        end
        @(posedge clk);
        #2;
        sample_strobe = 1'b0;
    endtask

    task automatic load_gains(input int kp_c, input int ki_c, input int kd_c);
        int codes [3];
        codes = '{kp_c, ki_c, kd_c};
        for (int i = 0; i < 3; i++) begin
            check_flag("running", 1'b0, running);
            cfg_strobe = 1'b1;
            gain_code  = CODE_W'(codes[i]);
            @(posedge clk);
            #2;
            cfg_strobe = 1'b0;
        end
        check_flag("running", 1'b1, running);
        kp = gain_lut[kp_c];
        ki = gain_lut[ki_c];
        kd = gain_lut[kd_c];
    endtask

    // Wait for all expected outputs, bounded
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never appeared on out_valid", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic reload_loop();
        drain();
        reload_strobe = 1'b1;
        @(posedge clk);
        #2;
        reload_strobe = 1'b0;
        check_flag("running", 1'b0, running);
        integ  = 0;
        prev_e = 0;
    endtask

    task automatic test_reset();
        check_out("control_out", '0, control_out);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("running", 1'b0, running);
        // Dropped while loading gains
        send_sample(200, 10, 1'b0);
        send_sample(50, 5, 1'b0);
        load_gains(10, 0, 0);
    endtask

    task automatic test_prop();
        send_sample(100, 40, 1'b1);
        send_sample(40, 100, 1'b1);
        send_sample(255, 0, 1'b1);
        // Gain code while running is ignored
        cfg_strobe = 1'b1;
        gain_code  = CODE_W'(15);
        @(posedge clk);
        #2;
        cfg_strobe = 1'b0;
        check_flag("running", 1'b1, running);
        send_sample(128, 128, 1'b1);
        send_sample(10, 0, 1'b1);
        drain();
    endtask

    task automatic test_integral();
        reload_loop();
        load_gains(0, 5, 0);
        repeat (6) send_sample(90, 70, 1'b1);
        drain();
    endtask

    task automatic test_deriv();
        reload_loop();
        load_gains(0, 0, 11);
        repeat (2) send_sample(100, 100, 1'b1);
        // Step in feedback
        repeat (3) send_sample(100, 60, 1'b1);
        drain();
    endtask

    task automatic test_random();
        // Both clamp limits with fixed gains
        reload_loop();
        load_gains(13, 2, 1);
        send_sample(200, 100, 1'b1);
        send_sample(100, 200, 1'b1);
        send_sample(120, 100, 1'b1);
        drain();
        repeat (4) begin
            reload_loop();
            load_gains($urandom_range(15), $urandom_range(15), $urandom_range(15));
            repeat (10) send_sample($urandom_range(255), $urandom_range(255), 1'b1);
            drain();
        end
    endtask

    task automatic test_reload();
        reload_loop();
        load_gains(10, 5, 0);
        repeat (4) send_sample(80, 50, 1'b1);
        drain();
        reload_loop();
        send_sample(120, 20, 1'b0);
        load_gains(5, 3, 2);
        repeat (5) send_sample(150, 100, 1'b1);
        drain();
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        cfg_strobe    = 1'b0;
        gain_code     = '0;
        sample_strobe = 1'b0;
        sample        = '0;
        reload_strobe = 1'b0;
        errors        = 0;
        cycles        = 0;
        integ         = 0;
        prev_e        = 0;
        assert_fails  = 0;
        void'($urandom(32'hf597));
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset();
        test_prop();
        test_integral();
        test_deriv();
        test_random();
        test_reload();
        drain();

        assert_fails = pid_loop_top_inst.pid_loop_properties_inst.fail_count;
        $display("Checks done, %0d errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/pid_cfg_pkg.sv
hw/pid_types_pkg.sv
hw/pid_sequencer.sv
hw/gain_table.sv
hw/error_stage.sv
hw/term_engine.sv
hw/pid_loop_top.sv
bench/pid_loop_properties.sv
bench/tb_pid_loop.sv

// ==== Bender.yml ====
package:
  name: pid_loop

sources:
  - hw/pid_cfg_pkg.sv
  - hw/pid_types_pkg.sv
  - hw/pid_sequencer.sv
  - hw/gain_table.sv
  - hw/error_stage.sv
  - hw/term_engine.sv
  - hw/pid_loop_top.sv
  - target: simulation
    files:
      - bench/pid_loop_properties.sv
      - bench/tb_pid_loop.sv
